// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;     // data and byte address
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;   // instr[31:26]
    typedef logic [5:0]  funct_t;    // instr[5:0], R-type only

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    // control transfer kinds, all with one delay slot
    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BGTZ,
        BR_BLEZ,
        BR_J,
        BR_JR
    } branch_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALTED       // also the reset state
    } cpu_state_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic        use_imm;     // operand b is the immediate
        word_t       imm;         // already sign or zero extended
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;          // rd for R-type, rt for I-type
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        branch_e     branch;
        logic [25:0] jump_index;
    } decoded_t;

    typedef struct packed {
        word_t address;
        logic  read;
        logic  write;
        word_t writedata;
    } bus_req_t;

endpackage

`default_nettype wire

// ==== verilog/mips_alu.sv ====
`default_nettype none

module mips_alu (
    input  wire mips_pkg::decoded_t  decoded,
    input  wire mips_pkg::word_t     rs_data,
    input  wire mips_pkg::word_t     rt_data,
    output mips_pkg::word_t          result,
    output logic                     branch_taken
);

    mips_pkg::word_t   operand_b;
    logic signed [31:0] rs_signed;
    logic signed [31:0] b_signed;
    logic               rs_zero;
    logic               rs_neg;

    assign operand_b = decoded.use_imm ? decoded.imm : rt_data;
    assign rs_signed = rs_data;
    assign b_signed  = operand_b;
    assign rs_zero   = (rs_data == '0);
    assign rs_neg    = rs_data[31];

    // for lw and sw this is the effective address
    always_comb begin
        case (decoded.alu_op)
            mips_pkg::ALU_SUB:  result = rs_data - operand_b;
            mips_pkg::ALU_AND:  result = rs_data & operand_b;
            mips_pkg::ALU_OR:   result = rs_data | operand_b;
            mips_pkg::ALU_XOR:  result = rs_data ^ operand_b;
            mips_pkg::ALU_SLT:  result = {31'b0, rs_signed < b_signed};
            mips_pkg::ALU_SLTU: result = {31'b0, rs_data < operand_b};
            mips_pkg::ALU_LUI:  result = {operand_b[15:0], 16'h0000};
            default:            result = rs_data + operand_b;   // addu, addiu
        endcase
    end

    // conditions compare against rt, never the immediate
    always_comb begin
        case (decoded.branch)
            mips_pkg::BR_BEQ:  branch_taken = (rs_data == rt_data);
            mips_pkg::BR_BNE:  branch_taken = (rs_data != rt_data);
            mips_pkg::BR_BGTZ: branch_taken = !rs_neg && !rs_zero;   // signed > 0
            mips_pkg::BR_BLEZ: branch_taken = rs_neg || rs_zero;
            mips_pkg::BR_J,
            mips_pkg::BR_JR:   branch_taken = 1'b1;
            default:           branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
`default_nettype none

module mips_regfile (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire mips_pkg::reg_idx_t  rs_idx,
    input  wire mips_pkg::reg_idx_t  rt_idx,
    input  wire mips_pkg::reg_idx_t  rd_idx,
    input  wire logic                reg_write,
    input  wire mips_pkg::word_t     write_data,
    output mips_pkg::word_t          rs_data,
    output mips_pkg::word_t          rt_data,
    output mips_pkg::word_t          v0
);

    mips_pkg::word_t regs [1:31];   // no storage behind $0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (reg_write && rd_idx != 5'd0) begin
            regs[rd_idx] <= write_data;
        end
    end

    // asynchronous reads, $0 reads as zero
    assign rs_data = (rs_idx == 5'd0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == 5'd0) ? '0 : regs[rt_idx];

    assign v0 = regs[2];

endmodule

`default_nettype wire

// ==== verilog/mips_pc.sv ====
`default_nettype none

module mips_pc #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                pc_step,
    input  wire mips_pkg::branch_e   branch_kind,
    input  wire logic                branch_taken,
    input  wire mips_pkg::word_t     branch_offset,   // sign-extended imm
    input  wire logic [25:0]         jump_index,
    input  wire mips_pkg::word_t     rs_data,
    output mips_pkg::word_t          pc,
    output logic                     halt
);

    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t target;
    mips_pkg::word_t pending;         // target waiting out the delay slot
    logic            pending_valid;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (branch_kind)
            mips_pkg::BR_J:  target = {pc_plus4[31:28], jump_index, 2'b00};
            mips_pkg::BR_JR: target = rs_data;
            default:         target = pc_plus4 + {branch_offset[29:0], 2'b00};
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc            <= RESET_VECTOR;
            pending_valid <= 1'b0;
            halt          <= 1'b0;
        end else if (pc_step) begin
            pc            <= pending_valid ? pending : pc_plus4;
            pending_valid <= branch_taken;
            // delay slot done, jumping to 0 ends the program
            if (pending_valid && pending == '0)
                halt <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_step && branch_taken)
            pending <= target;
    end

endmodule

`default_nettype wire

// ==== verilog/mips_control.sv ====
`default_nettype none

module mips_control (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic                waitrequest,
    input  wire mips_pkg::word_t     readdata,
    input  wire mips_pkg::word_t     pc,
    input  wire logic                halt,
    input  wire mips_pkg::word_t     alu_result,
    input  wire mips_pkg::word_t     rt_data,
    output mips_pkg::bus_req_t       bus_req,
    output mips_pkg::decoded_t       decoded,
    output logic                     pc_step,
    output logic                     reg_write,
    output mips_pkg::word_t          write_data,
    output logic                     active
);

    localparam mips_pkg::opcode_t OP_SPECIAL = 6'h00;
    localparam mips_pkg::opcode_t OP_J       = 6'h02;
    localparam mips_pkg::opcode_t OP_BEQ     = 6'h04;
    localparam mips_pkg::opcode_t OP_BNE     = 6'h05;
    localparam mips_pkg::opcode_t OP_BLEZ    = 6'h06;
    localparam mips_pkg::opcode_t OP_BGTZ    = 6'h07;
    localparam mips_pkg::opcode_t OP_ADDIU   = 6'h09;
    localparam mips_pkg::opcode_t OP_ANDI    = 6'h0c;
    localparam mips_pkg::opcode_t OP_ORI     = 6'h0d;
    localparam mips_pkg::opcode_t OP_XORI    = 6'h0e;
    localparam mips_pkg::opcode_t OP_LUI     = 6'h0f;
    localparam mips_pkg::opcode_t OP_LW      = 6'h23;
    localparam mips_pkg::opcode_t OP_SW      = 6'h2b;

    localparam mips_pkg::funct_t FN_JR   = 6'h08;
    localparam mips_pkg::funct_t FN_ADDU = 6'h21;
    localparam mips_pkg::funct_t FN_SUBU = 6'h23;
    localparam mips_pkg::funct_t FN_AND  = 6'h24;
    localparam mips_pkg::funct_t FN_OR   = 6'h25;
    localparam mips_pkg::funct_t FN_XOR  = 6'h26;
    localparam mips_pkg::funct_t FN_SLT  = 6'h2a;
    localparam mips_pkg::funct_t FN_SLTU = 6'h2b;

    mips_pkg::cpu_state_e state;
    logic                 started;     // set once the first fetch is launched
    mips_pkg::word_t      instr;
    mips_pkg::word_t      load_data;
    mips_pkg::opcode_t    opcode;
    mips_pkg::funct_t     funct;
    logic                 mem_op;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign mem_op = decoded.mem_read || decoded.mem_write;

    always_comb begin
        decoded            = '0;
        decoded.alu_op     = mips_pkg::ALU_ADD;
        decoded.imm        = {{16{instr[15]}}, instr[15:0]};
        decoded.rs         = instr[25:21];
        decoded.rt         = instr[20:16];
        decoded.rd         = instr[15:11];
        decoded.branch     = mips_pkg::BR_NONE;
        decoded.jump_index = instr[25:0];
        case (opcode)
            OP_SPECIAL: begin
                decoded.reg_write = 1'b1;
                case (funct)
                    FN_ADDU: decoded.alu_op = mips_pkg::ALU_ADD;
                    FN_SUBU: decoded.alu_op = mips_pkg::ALU_SUB;
                    FN_AND:  decoded.alu_op = mips_pkg::ALU_AND;
                    FN_OR:   decoded.alu_op = mips_pkg::ALU_OR;
                    FN_XOR:  decoded.alu_op = mips_pkg::ALU_XOR;
                    FN_SLT:  decoded.alu_op = mips_pkg::ALU_SLT;
                    FN_SLTU: decoded.alu_op = mips_pkg::ALU_SLTU;
                    FN_JR: begin
                        decoded.reg_write = 1'b0;
                        decoded.branch    = mips_pkg::BR_JR;
                    end
                    default: decoded.reg_write = 1'b0;   // sll $0 nop lands here
                endcase
            end
            OP_J:    decoded.branch = mips_pkg::BR_J;
            OP_BEQ:  decoded.branch = mips_pkg::BR_BEQ;
            OP_BNE:  decoded.branch = mips_pkg::BR_BNE;
            OP_BLEZ: decoded.branch = mips_pkg::BR_BLEZ;
            OP_BGTZ: decoded.branch = mips_pkg::BR_BGTZ;
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                decoded.use_imm   = 1'b1;
                decoded.rd        = instr[20:16];
                decoded.reg_write = 1'b1;
                if (opcode != OP_ADDIU)
                    decoded.imm = {16'h0000, instr[15:0]};   // logic ops zero-extend
                case (opcode)
                    OP_ANDI: decoded.alu_op = mips_pkg::ALU_AND;
                    OP_ORI:  decoded.alu_op = mips_pkg::ALU_OR;
                    OP_XORI: decoded.alu_op = mips_pkg::ALU_XOR;
                    OP_LUI:  decoded.alu_op = mips_pkg::ALU_LUI;
                    default: decoded.alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            OP_LW: begin
                decoded.use_imm   = 1'b1;
                decoded.rd        = instr[20:16];
                decoded.reg_write = 1'b1;
                decoded.mem_read  = 1'b1;
            end
            OP_SW: begin
                decoded.use_imm   = 1'b1;
                decoded.mem_write = 1'b1;
            end
            default: ;   // unknown opcode, nothing happens
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= mips_pkg::ST_HALTED;
            started <= 1'b0;
            instr   <= '0;
        end else begin
            case (state)
                mips_pkg::ST_HALTED: begin
                    if (!started) begin   // leave only once after reset
                        state   <= mips_pkg::ST_FETCH;
                        started <= 1'b1;
                    end
                end
                mips_pkg::ST_FETCH: begin
                    if (!waitrequest) begin
                        instr <= readdata;
                        state <= mips_pkg::ST_EXECUTE;
                    end
                end
                mips_pkg::ST_EXECUTE:
                    state <= mem_op ? mips_pkg::ST_MEMORY : mips_pkg::ST_WRITEBACK;
                mips_pkg::ST_MEMORY:
                    if (!waitrequest) state <= mips_pkg::ST_WRITEBACK;
                mips_pkg::ST_WRITEBACK:
                    state <= halt ? mips_pkg::ST_HALTED : mips_pkg::ST_FETCH;
                default: state <= mips_pkg::ST_HALTED;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mips_pkg::ST_MEMORY && !waitrequest)
            load_data <= readdata;
    end

    // request is a function of state and values that hold during a stall
    always_comb begin
        bus_req.address   = (state == mips_pkg::ST_MEMORY) ? alu_result : pc;
        bus_req.read      = (state == mips_pkg::ST_FETCH)
                          || (state == mips_pkg::ST_MEMORY && decoded.mem_read);
        bus_req.write     = (state == mips_pkg::ST_MEMORY) && decoded.mem_write;
        bus_req.writedata = bus_req.write ? rt_data : '0;
    end

    assign pc_step    = (state == mips_pkg::ST_EXECUTE);
    assign reg_write  = (state == mips_pkg::ST_WRITEBACK) && decoded.reg_write;
    assign write_data = decoded.mem_read ? load_data : alu_result;
    assign active     = (state != mips_pkg::ST_HALTED);

endmodule

`default_nettype wire

// ==== verilog/mips_cpu.sv ====
`default_nettype none

module mips_cpu #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'hbfc0_0000
) (
    input  wire logic                clk,
    input  wire logic                arst_n,
    output logic                     active,
    output mips_pkg::word_t          register_v0,

    // avalon master
    output mips_pkg::word_t          address,
    output logic                     read,
    output logic                     write,
    output mips_pkg::word_t          writedata,
    input  wire logic                waitrequest,
    input  wire mips_pkg::word_t     readdata
);

    mips_pkg::bus_req_t bus_req;
    mips_pkg::decoded_t decoded;
    logic               pc_step;
    logic               reg_write;
    mips_pkg::word_t    write_data;
    mips_pkg::word_t    pc;
    logic               halt;
    mips_pkg::word_t    alu_result;
    logic               branch_taken;
    mips_pkg::word_t    rs_data;
    mips_pkg::word_t    rt_data;

    mips_control i_control (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .pc          (pc),
        .halt        (halt),
        .alu_result  (alu_result),
        .rt_data     (rt_data),
        .bus_req     (bus_req),
        .decoded     (decoded),
        .pc_step     (pc_step),
        .reg_write   (reg_write),
        .write_data  (write_data),
        .active      (active)
    );

    mips_pc #(
        .RESET_VECTOR (RESET_VECTOR)
    ) i_pc (
        .clk           (clk),
        .arst_n        (arst_n),
        .pc_step       (pc_step),
        .branch_kind   (decoded.branch),
        .branch_taken  (branch_taken),
        .branch_offset (decoded.imm),
        .jump_index    (decoded.jump_index),
        .rs_data       (rs_data),
        .pc            (pc),
        .halt          (halt)
    );

    mips_regfile i_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .rs_idx     (decoded.rs),
        .rt_idx     (decoded.rt),
        .rd_idx     (decoded.rd),
        .reg_write  (reg_write),
        .write_data (write_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .v0         (register_v0)
    );

    mips_alu i_alu (
        .decoded      (decoded),
        .rs_data      (rs_data),
        .rt_data      (rt_data),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    assign address   = bus_req.address;
    assign read      = bus_req.read;
    assign write     = bus_req.write;
    assign writedata = bus_req.writedata;

endmodule

`default_nettype wire

// ==== sim/avalon_ram.sv ====
`default_nettype none

module avalon_ram #(
    parameter int RAM_WORDS = 256
) (
    input  wire logic             clk,
    input  wire mips_pkg::word_t  address,
    input  wire logic             read,
    input  wire logic             write,
    input  wire mips_pkg::word_t  writedata,
    input  wire logic             rand_wait,
    output logic                  waitrequest,
    output mips_pkg::word_t       readdata
);

    localparam int AW = $clog2(RAM_WORDS);

    mips_pkg::word_t mem [RAM_WORDS];
    logic [AW-1:0]   index;
    logic [1:0]      stall_count;    // cycles the current request has waited
    logic [1:0]      stall_target;   // drawn when the previous transfer completed

    assign index       = address[AW+1:2];
    assign readdata    = mem[index];
    assign waitrequest = (read || write) && (stall_count != stall_target);

    always @(posedge clk) begin
        if (read || write) begin
            if (waitrequest) begin
                stall_count <= stall_count + 2'd1;
            end else begin
                if (write)
                    mem[index] <= writedata;
                stall_count  <= 2'd0;
                stall_target <= rand_wait ? 2'($urandom_range(3, 0)) : 2'd0;
            end
        end
    end

    // back door for the testbench
    task automatic clear();
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] <= '0;
        stall_count  <= 2'd0;
        stall_target <= 2'd0;
    endtask

    task automatic load_word(input mips_pkg::word_t byte_addr, input mips_pkg::word_t data);
        mem[byte_addr[AW+1:2]] <= data;
    endtask

    function automatic mips_pkg::word_t read_word(input mips_pkg::word_t byte_addr);
        return mem[byte_addr[AW+1:2]];
    endfunction

endmodule

`default_nettype wire

// ==== sim/mips_cpu_assertions.sv ====
`default_nettype none

module mips_cpu_assertions (
    input wire logic             clk,
    input wire logic             arst_n,
    input wire logic             active,
    input wire logic             read,
    input wire logic             write,
    input wire logic             waitrequest,
    input wire mips_pkg::word_t  address,
    input wire mips_pkg::word_t  writedata
);

    int   failures = 0;
    logic fresh;   // high until the first edge after reset

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            fresh <= 1'b1;
        else
            fresh <= 1'b0;
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(read && write))
        else begin
            $error("read and write high in the same cycle");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!arst_n)
                     (read || write) |-> address[1:0] == 2'b00)
        else begin
            $error("request address not word aligned");
            failures++;
        end

    // a stalled request must not move
    assert property (@(posedge clk) disable iff (!arst_n)
                     (read || write) && waitrequest |=> $stable({address, read, write, writedata}))
        else begin
            $error("request changed while waitrequest was high");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) $rose(active) |-> $past(fresh))
        else begin
            $error("active rose other than right after reset");
            failures++;
        end

    assert property (@(posedge clk) disable iff (!arst_n) !active |-> !read && !write)
        else begin
            $error("bus request while the core is not active");
            failures++;
        end

endmodule

bind mips_cpu mips_cpu_assertions i_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata)
);

`default_nettype wire

// ==== sim/mips_cpu_tb.sv ====
`default_nettype none

module mips_cpu_tb;

    localparam int RAM_WORDS = 256;
    localparam int TIMEOUT   = 2000;   // cycles allowed per wait
    localparam int QUIET     = 8;      // cycles watched after the halt

    logic            clk;
    logic            arst_n;
    logic            rand_wait;
    logic            wait_mode;        // taken from the stim file, applied in reset
    logic            active;
    logic            read;
    logic            write;
    logic            waitrequest;
    mips_pkg::word_t register_v0;
    mips_pkg::word_t address;
    mips_pkg::word_t writedata;
    mips_pkg::word_t readdata;
    mips_pkg::word_t expected_v0;
    mips_pkg::word_t check_addr [$];
    mips_pkg::word_t check_word [$];
    int              abort_after;      // cycles before a mid-run reset, 0 for none
    int              test_count;

    mips_cpu #(
        .RESET_VECTOR (32'h0000_0004)
    ) i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    avalon_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) i_ram (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .rand_wait   (rand_wait),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input mips_pkg::word_t got,
                               input mips_pkg::word_t want);
        abort_run($sformatf("error %s got %h expected %h", name, got, want));
    endtask

    task automatic check_fields(input int got, input int want);
        assert (got == want)
            else abort_run("stim record has missing or malformed fields");
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n    = 1'b0;
        rand_wait = wait_mode;
        repeat (16) @(negedge clk);
        assert (!active && !read && !write)
            else abort_run("bus request or active seen during reset");
        assert (register_v0 == '0)   // every register clears in reset
            else value_error("register_v0", register_v0, 32'h0);
        arst_n = 1'b1;
    endtask

    task automatic run_program();
        int              cycles;
        mips_pkg::word_t got;
        if (abort_after > 0) begin
            apply_reset();
            repeat (abort_after) @(negedge clk);
            assert (active) else abort_run("program ended before the mid-run reset");
        end
        apply_reset();
        @(negedge clk);   // active must rise on the first edge
        assert (active) else value_error("active", active, 32'h1);
        cycles = 0;
        while (active) begin
            @(negedge clk);
            cycles++;
            if (cycles >= TIMEOUT)
                abort_run("active did not fall within 2000 cycles");
        end
        assert (register_v0 == expected_v0)
            else value_error("register_v0", register_v0, expected_v0);
        foreach (check_addr[i]) begin
            got = i_ram.read_word(check_addr[i]);
            assert (got == check_word[i])
                else value_error($sformatf("mem[%h]", check_addr[i]), got, check_word[i]);
        end
        repeat (QUIET) begin
            @(negedge clk);
            assert (!active && !read && !write)
                else abort_run("bus request or active seen after the halt");
        end
        abort_after = 0;
        test_count++;
    endtask

    always @(negedge clk) begin
        assert (i_dut.i_assertions.failures == 0)
            else abort_run("a bus protocol assertion failed");
    end

    initial begin
        int               fd;
        int               code;
        logic [7:0]       cmd;
        mips_pkg::word_t  addr;
        mips_pkg::word_t  data;
        logic [8*128-1:0] line;
        arst_n      = 1'b0;
        rand_wait   = 1'b0;
        wait_mode   = 1'b0;
        expected_v0 = '0;
        abort_after = 0;
        test_count  = 0;
        void'($urandom(32'ha8dd_bc9c));
        fd = $fopen("sim/mips_cpu_stim.txt", "r");
        if (fd == 0)
            abort_run("cannot open sim/mips_cpu_stim.txt");
        while ($fscanf(fd, " %c", cmd) == 1) begin
            case (cmd)
                "#": code = $fgets(line, fd);   // comment line
                "p": begin
                    i_ram.clear();
                    check_addr.delete();
                    check_word.delete();
                end
                "w": begin
                    code = $fscanf(fd, " %h %h", addr, data);
                    check_fields(code, 2);
                    i_ram.load_word(addr, data);
                end
                "r": begin
                    code      = $fscanf(fd, " %h", data);
                    check_fields(code, 1);
                    wait_mode = data[0];
                end
                "v": begin
                    code = $fscanf(fd, " %h", expected_v0);
                    check_fields(code, 1);
                end
                "m": begin
                    code = $fscanf(fd, " %h %h", addr, data);
                    check_fields(code, 2);
                    check_addr.push_back(addr);
                    check_word.push_back(data);
                end
                "a": begin
                    code = $fscanf(fd, " %d", abort_after);
                    check_fields(code, 1);
                end
                "g": run_program();
                default: abort_run($sformatf("unknown stim record %c", cmd));
            endcase
        end
        $fclose(fd);
        if (test_count == 0 || i_dut.i_assertions.failures != 0) begin
            abort_run("no test ran or a bus assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/mips_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_pc.sv
verilog/mips_control.sv
verilog/mips_cpu.sv
sim/avalon_ram.sv
sim/mips_cpu_assertions.sv
sim/mips_cpu_tb.sv

// ==== sim/mips_cpu_stim.txt ====
# p new test and clear memory, w byte_addr word, r rand_wait, v expected v0,
# m byte_addr word expected after the halt, a cycles before a mid-run reset, g run
# straight-line arithmetic
p
r 0
w 04 24080005
w 08 3C091234
w 0C 35295678
w 10 01285021
w 14 01495823
w 18 240CFFFF
w 1C 01896824
w 20 01AA7026
w 24 0188782A
w 28 010CC02B
w 2C 01AF1021
w 30 004E1021
w 34 004B1021
w 38 00581021
w 3C 00000008
v 12345684
g
# bgtz on a negative register is not taken
p
w 04 2403FFFF
w 08 1C600002
w 0C 24020020
w 10 24420030
w 14 24420050
w 18 00000008
v 000000A0
g
# beq, bne and blez taken, each delay slot adds one bit
p
w 04 24040007
w 08 24050007
w 0C 10850003
w 10 24020001
w 14 24420100
w 18 24420200
w 1C 14800002
w 20 24420002
w 24 24420400
w 28 18000002
w 2C 24420004
w 30 24420800
w 34 00000008
w 38 24420008
v 0000000F
g
# j and jr with delay slots, halt after the jr $0 slot
p
r 1
w 04 08000010
w 08 24020010
w 0C 24421000
w 40 24030060
w 44 00600008
w 48 24420020
w 4C 24422000
w 60 24420040
w 64 00000008
w 68 24420080
w 6C 24424000
v 000000F0
g
# sw and lw round trips with random waitrequest
p
r 1
w 04 24080200
w 08 3C09CAFE
w 0C 3529BABE
w 10 AD090000
w 14 AD080004
w 18 8D0A0000
w 1C 8D0B0004
w 20 8D0C0008
w 24 014B1021
w 28 004C1021
w 2C AD02000C
w 30 00000008
w 208 00000011
v CAFEBCCF
m 200 CAFEBABE
m 204 00000200
m 208 00000011
m 20C CAFEBCCF
g
# same program again with a reset in the middle of the first run
a 30
g
